// ==== src/calc_params.svh ====
// Calculator core parameters
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

// Sign-magnitude number layout
`define CALC_WIDTH 16
`define CALC_MAG_WIDTH 15

// Flops in each key level synchronizer
`define CALC_SYNC_STAGES 2

// One multiplier iteration per magnitude bit
`define CALC_MULT_STEPS `CALC_MAG_WIDTH

// Decimal digit entry
`define CALC_DIGIT_BASE 10

`endif

// ==== src/calc_pkg.sv ====
// Calculator shared types
`include "calc_params.svh"

package calc_pkg;

    // Bit 15 sign, lower bits magnitude
    typedef struct packed {
        logic                       sign;
        logic [`CALC_MAG_WIDTH-1:0] mag;
    } calc_num_t;

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } calc_op_t;

    // One-cycle key strobe, at most one kind set
    typedef struct packed {
        logic       digit_valid;
        logic [3:0] digit;
        calc_op_t   op;
        logic       equal;
    } key_event_t;

    typedef enum logic [3:0] {
        WAIT_OP1,
        SCALE_OP1,
        ADD_DIGIT_OP1,
        WAIT_OP2,
        SCALE_OP2,
        ADD_DIGIT_OP2,
        DISPATCH,
        WAIT_RESULT,
        SHOW_RESULT
    } ctrl_state_t;

endpackage

// ==== src/key_event_sync.sv ====
// Key level synchronizer and edge detector
`include "calc_params.svh"

module key_event_sync
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] keypad_input,
    input  logic       read_input,
    input  logic [2:0] operator_input,
    input  logic       equal_input,
    output key_event_t key_evt
);

    localparam int STAGES = `CALC_SYNC_STAGES;
    localparam int LVL_W  = 9;

    logic [LVL_W-1:0]             raw_lvl;
    logic [STAGES-1:0][LVL_W-1:0] sync_q;
    logic [3:0]                   digit_s;
    logic                         read_s;
    logic [2:0]                   op_s;
    logic                         equal_s;
    logic                         read_prev, op_prev, equal_prev;
    logic                         read_rise, op_rise, equal_rise;

    assign raw_lvl = {keypad_input, read_input, operator_input, equal_input};
    assign {digit_s, read_s, op_s, equal_s} = sync_q[STAGES-1];

    // An operator button counts as pressed while its code is nonzero
    assign read_rise  = read_s && !read_prev;
    assign op_rise    = (|op_s) && !op_prev;
    assign equal_rise = equal_s && !equal_prev;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            sync_q     <= '0;
            read_prev  <= 1'b0;
            op_prev    <= 1'b0;
            equal_prev <= 1'b0;
            key_evt    <= '0;
        end else begin
            sync_q[0] <= raw_lvl;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            read_prev  <= read_s;
            op_prev    <= |op_s;
            equal_prev <= equal_s;

            // Digit wins over operator, operator over equal
            key_evt <= '0;
            if (read_rise) begin
                key_evt.digit_valid <= 1'b1;
                key_evt.digit       <= digit_s;
            end else if (op_rise) begin
                key_evt.op <= calc_op_t'(op_s);
            end else if (equal_rise) begin
                key_evt.equal <= 1'b1;
            end
        end
    end

    a_one_event_kind: assert property (@(posedge clk) disable iff (!nRST)
        $onehot0({key_evt.digit_valid, key_evt.op != OP_NONE, key_evt.equal}));

endmodule

// ==== src/calc_controller.sv ====
// Calculator control FSM
`include "calc_params.svh"

module calc_controller
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  key_event_t key_evt,
    input  calc_num_t  add_result,
    input  logic       add_done,
    input  calc_num_t  mul_result,
    input  logic       mul_done,
    output logic       key_read,
    output logic       complete,
    output calc_num_t  display_output,
    output calc_num_t  add_a,
    output calc_num_t  add_b,
    output logic       add_sub,
    output logic       add_start,
    output calc_num_t  mul_a,
    output calc_num_t  mul_b,
    output logic       mul_start
);

    localparam int        MAG_W = `CALC_MAG_WIDTH;
    localparam calc_num_t TEN   = '{sign: 1'b0, mag: MAG_W'(`CALC_DIGIT_BASE)};

    ctrl_state_t      state, next_state;
    calc_num_t        op1, op2, cur_operand;
    calc_op_t         op_q;
    logic [3:0]       digit_q;
    logic [MAG_W-1:0] digit_ext;
    logic             is_neg, is_arith, accept, result_done;

    assign is_neg      = key_evt.op == OP_NEG;
    assign is_arith    = key_evt.op inside {OP_ADD, OP_SUB, OP_MUL};
    assign cur_operand = (state == WAIT_OP2) ? op2 : op1;
    assign digit_ext   = MAG_W'(digit_q);
    assign result_done = (op_q == OP_MUL) ? mul_done : add_done;

    // Keys are only taken while waiting for operand input
    always_comb begin
        case (state)
            WAIT_OP1: accept = key_evt.digit_valid || is_neg || is_arith;
            WAIT_OP2: accept = key_evt.digit_valid || is_neg || key_evt.equal;
            default:  accept = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            WAIT_OP1: begin
                if (key_evt.digit_valid) begin
                    next_state = SCALE_OP1;
                end else if (is_arith) begin
                    next_state = WAIT_OP2;
                end
            end
            SCALE_OP1:     next_state = mul_done ? ADD_DIGIT_OP1 : SCALE_OP1;
            ADD_DIGIT_OP1: next_state = WAIT_OP1;
            WAIT_OP2: begin
                if (key_evt.digit_valid) begin
                    next_state = SCALE_OP2;
                end else if (key_evt.equal) begin
                    next_state = DISPATCH;
                end
            end
            SCALE_OP2:     next_state = mul_done ? ADD_DIGIT_OP2 : SCALE_OP2;
            ADD_DIGIT_OP2: next_state = WAIT_OP2;
            DISPATCH:      next_state = WAIT_RESULT;
            WAIT_RESULT:   next_state = result_done ? SHOW_RESULT : WAIT_RESULT;
            default:       next_state = WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= WAIT_OP1;
            key_read       <= 1'b0;
            complete       <= 1'b0;
            add_start      <= 1'b0;
            mul_start      <= 1'b0;
            display_output <= '0;
            op1            <= '0;
            op2            <= '0;
            op_q           <= OP_NONE;
        end else begin
            state     <= next_state;
            key_read  <= accept;
            complete  <= 1'b0;
            add_start <= 1'b0;
            mul_start <= 1'b0;
            case (state)
                WAIT_OP1: begin
                    if (key_evt.digit_valid) begin
                        mul_start <= 1'b1;
                    end else if (is_neg) begin
                        op1.sign <= ~op1.sign;
                    end else if (is_arith) begin
                        op_q <= key_evt.op;
                    end
                end
                WAIT_OP2: begin
                    if (key_evt.digit_valid) begin
                        mul_start <= 1'b1;
                    end else if (is_neg) begin
                        op2.sign <= ~op2.sign;
                    end
                end
                // Sign stays with the operand, only the magnitude is scaled
                SCALE_OP1:     if (mul_done) op1.mag <= mul_result.mag;
                ADD_DIGIT_OP1: op1.mag <= op1.mag + digit_ext;
                SCALE_OP2:     if (mul_done) op2.mag <= mul_result.mag;
                ADD_DIGIT_OP2: op2.mag <= op2.mag + digit_ext;
                DISPATCH: begin
                    if (op_q == OP_MUL) begin
                        mul_start <= 1'b1;
                    end else begin
                        add_start <= 1'b1;
                    end
                end
                SHOW_RESULT: begin
                    display_output <= (op_q == OP_MUL) ? mul_result : add_result;
                    complete       <= 1'b1;
                    op1            <= '0;
                    op2            <= '0;
                end
                default: ;
            endcase
        end
    end

    // Operand registers for the arithmetic units
    always_ff @(posedge clk) begin
        if (accept && key_evt.digit_valid) begin
            digit_q <= key_evt.digit;
            mul_a   <= cur_operand;
            mul_b   <= TEN;
        end else if (state == DISPATCH) begin
            add_a   <= op1;
            add_b   <= op2;
            add_sub <= op_q == OP_SUB;
            mul_a   <= op1;
            mul_b   <= op2;
        end
    end

    a_complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete);

    a_single_start: assert property (@(posedge clk) disable iff (!nRST)
        !(add_start && mul_start));

endmodule

// ==== src/signmag_adder.sv ====
// Sign-magnitude adder and subtractor
`include "calc_params.svh"

module signmag_adder
    import calc_pkg::*;
(
    input  logic      clk,
    input  logic      nRST,
    input  calc_num_t a,
    input  calc_num_t b,
    input  logic      sub,
    input  logic      start,
    output calc_num_t result,
    output logic      done
);

    localparam int MAG_W = `CALC_MAG_WIDTH;

    logic             b_sign;
    logic             sum_sign;
    logic [MAG_W-1:0] sum_mag;

    always_comb begin
        b_sign = b.sign ^ sub;
        if (a.sign == b_sign) begin
            // Wraps modulo 2^15
            sum_mag  = a.mag + b.mag;
            sum_sign = a.sign;
        end else if (a.mag >= b.mag) begin
            sum_mag  = a.mag - b.mag;
            sum_sign = a.sign;
        end else begin
            sum_mag  = b.mag - a.mag;
            sum_sign = b_sign;
        end
        if (sum_mag == '0) begin
            sum_sign = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= '{sign: sum_sign, mag: sum_mag};
        end
    end

    a_no_neg_zero: assert property (@(posedge clk) disable iff (!nRST)
        done |-> !(result.sign && result.mag == '0));

endmodule

// ==== src/shift_add_multiplier.sv ====
// Iterative shift-add multiplier
`include "calc_params.svh"

module shift_add_multiplier
    import calc_pkg::*;
(
    input  logic      clk,
    input  logic      nRST,
    input  calc_num_t a,
    input  calc_num_t b,
    input  logic      start,
    output calc_num_t result,
    output logic      done
);

    localparam int               MAG_W     = `CALC_MAG_WIDTH;
    localparam int               STEPS     = `CALC_MULT_STEPS;
    localparam int               CNT_W     = $clog2(STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(STEPS - 1);

    logic             busy;
    logic [CNT_W-1:0] step;
    logic [MAG_W-1:0] acc, acc_next;
    logic [MAG_W-1:0] mcand, mplier;
    logic             sign_q;

    // Partial product for the current multiplier bit
    assign acc_next = mplier[0] ? acc + mcand : acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == LAST_STEP) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= a.mag;
            mplier <= b.mag;
            sign_q <= a.sign ^ b.sign;
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (step == LAST_STEP) begin
                result <= '{sign: sign_q && (acc_next != '0), mag: acc_next};
            end
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!nRST)
        start |-> !busy);

endmodule

// ==== src/calculator_top.sv ====
// Calculator core top level
module calculator_top
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] keypad_input,
    input  logic       read_input,
    input  logic [2:0] operator_input,
    input  logic       equal_input,
    output logic       key_read,
    output logic       complete,
    output calc_num_t  display_output
);

    key_event_t key_evt;
    calc_num_t  add_a, add_b, add_result;
    logic       add_sub, add_start, add_done;
    calc_num_t  mul_a, mul_b, mul_result;
    logic       mul_start, mul_done;

    key_event_sync sync0 (
        .clk(clk), .nRST(nRST),
        .keypad_input(keypad_input), .read_input(read_input),
        .operator_input(operator_input), .equal_input(equal_input),
        .key_evt(key_evt)
    );

    calc_controller ctrl0 (
        .clk(clk), .nRST(nRST), .key_evt(key_evt),
        .add_result(add_result), .add_done(add_done),
        .mul_result(mul_result), .mul_done(mul_done),
        .key_read(key_read), .complete(complete), .display_output(display_output),
        .add_a(add_a), .add_b(add_b), .add_sub(add_sub), .add_start(add_start),
        .mul_a(mul_a), .mul_b(mul_b), .mul_start(mul_start)
    );

    signmag_adder add0 (
        .clk(clk), .nRST(nRST), .a(add_a), .b(add_b), .sub(add_sub),
        .start(add_start), .result(add_result), .done(add_done)
    );

    shift_add_multiplier mul0 (
        .clk(clk), .nRST(nRST), .a(mul_a), .b(mul_b),
        .start(mul_start), .result(mul_result), .done(mul_done)
    );

endmodule

// ==== verification/calculator_tb.sv ====
// Calculator core testbench
`include "calc_params.svh"

module calculator_tb
    import calc_pkg::*;
();

    localparam int MAG_W        = `CALC_MAG_WIDTH;
    localparam int MAG_MOD      = 1 << MAG_W;
    localparam int CALC_TIMEOUT = 200;
    // Up to 12 presses for each random calculation
    localparam int PRESS_COUNT     = 6 + 8 + 19 + 6 + 20 * 12;
    localparam int WATCHDOG_CYCLES = PRESS_COUNT * 40 + 1000;

    logic        clk;
    logic        nRST;
    logic [3:0]  keypad_input;
    logic        read_input;
    logic [2:0]  operator_input;
    logic        equal_input;
    logic        key_read;
    logic        complete;
    calc_num_t   display_output;
    logic [31:0] lfsr_state;
    calc_num_t   last_expected = '0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          key_read_count = 0;
    int          complete_count = 0;

    calculator_top dut0 (
        .clk(clk), .nRST(nRST),
        .keypad_input(keypad_input), .read_input(read_input),
        .operator_input(operator_input), .equal_input(equal_input),
        .key_read(key_read), .complete(complete), .display_output(display_output)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Count key_read and complete pulses
    initial begin
        fork
            forever begin
                @(negedge clk);
                if (key_read) key_read_count++;
            end
            forever begin
                @(negedge clk);
                if (complete) complete_count++;
            end
        join
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // Expected result from signed arithmetic folded back to sign-magnitude
    function automatic calc_num_t model_result(input calc_num_t a, input calc_num_t b,
                                               input calc_op_t op);
        int        va;
        int        vb;
        int        sum;
        calc_num_t r;
        if (op == OP_MUL) begin
            r.mag  = MAG_W'((int'(a.mag) * int'(b.mag)) % MAG_MOD);
            r.sign = a.sign ^ b.sign;
        end else begin
            va     = a.sign ? -int'(a.mag) : int'(a.mag);
            vb     = (b.sign ^ (op == OP_SUB)) ? -int'(b.mag) : int'(b.mag);
            sum    = va + vb;
            r.sign = sum < 0;
            r.mag  = MAG_W'(((sum < 0) ? -sum : sum) % MAG_MOD);
        end
        if (r.mag == '0) begin
            r.sign = 1'b0;
        end
        return r;
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    task automatic press_digit(input logic [3:0] d);
        @(posedge clk);
        keypad_input <= d;
        read_input   <= 1'b1;
        repeat (4) @(posedge clk);
        keypad_input <= 4'd0;
        read_input   <= 1'b0;
        repeat (30) @(posedge clk);
    endtask

    task automatic press_op(input calc_op_t op);
        @(posedge clk);
        operator_input <= op;
        repeat (4) @(posedge clk);
        operator_input <= OP_NONE;
        repeat (30) @(posedge clk);
    endtask

    task automatic press_equal();
        @(posedge clk);
        equal_input <= 1'b1;
        repeat (4) @(posedge clk);
        equal_input <= 1'b0;
        repeat (30) @(posedge clk);
    endtask

    // Most significant digit first and negate after the last digit
    task automatic enter_operand(input int value, input bit neg, output calc_num_t num,
                                 output int presses);
        int digits[$];
        int v;
        v   = value;
        num = '0;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v > 0);
        foreach (digits[i]) begin
            press_digit(4'(digits[i]));
            num.mag = MAG_W'((int'(num.mag) * 10 + digits[i]) % MAG_MOD);
        end
        presses = digits.size();
        if (neg) begin
            press_op(OP_NEG);
            num.sign = ~num.sign;
            presses++;
        end
    endtask

    task automatic wait_complete(input int start_count);
        int cycles;
        cycles = 0;
        while (complete_count == start_count && cycles < CALC_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (complete_count == start_count) begin
            $display("Error at %0t: complete never arrived", $time);
            errors++;
        end
    endtask

    task automatic run_calc(input int v1, input bit n1, input calc_op_t op,
                            input int v2, input bit n2);
        calc_num_t a;
        calc_num_t b;
        calc_num_t exp;
        int        p1;
        int        p2;
        int        reads0;
        int        done0;
        @(posedge clk);
        reads0 = key_read_count;
        done0  = complete_count;
        enter_operand(v1, n1, a, p1);
        press_op(op);
        enter_operand(v2, n2, b, p2);
        press_equal();
        wait_complete(done0);
        exp           = model_result(a, b, op);
        last_expected = exp;
        check_val("complete pulses", complete_count - done0, 1);
        check_val("key_read pulses", key_read_count - reads0, p1 + p2 + 2);
        @(negedge clk);
        check_val("display_output", display_output, exp);
    endtask

    task automatic reset_values();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_val("display_output", display_output, 0);
        check_val("complete", complete, 0);
        check_val("key_read", key_read, 0);
        report_test("reset values", e0);
    endtask

    task automatic ignored_keys();
        int        e0;
        int        reads0;
        int        done0;
        calc_num_t a;
        calc_num_t b;
        int        p;
        e0 = errors;
        @(posedge clk);
        reads0 = key_read_count;
        done0  = complete_count;
        // Equal with no operator pending
        press_equal();
        check_val("key_read pulses", key_read_count - reads0, 0);
        check_val("complete pulses", complete_count - done0, 0);
        check_val("display_output", display_output, last_expected);
        reads0 = key_read_count;
        enter_operand(3, 1'b0, a, p);
        press_op(OP_ADD);
        press_op(OP_MUL);
        enter_operand(2, 1'b0, b, p);
        press_equal();
        wait_complete(done0);
        check_val("key_read pulses", key_read_count - reads0, 4);
        @(negedge clk);
        check_val("display_output", display_output, model_result(a, b, OP_ADD));
        report_test("ignored keys", e0);
    endtask

    task automatic random_operand(output int value, output bit neg);
        int nd;
        int d;
        int s;
        take_bits(2, nd);
        value = 0;
        for (int i = 0; i <= nd; i++) begin
            take_bits(4, d);
            value = value * 10 + d % 10;
        end
        take_bits(1, s);
        neg = s[0];
    endtask

    task automatic random_calculations();
        int       e0;
        int       v1;
        int       v2;
        int       k;
        bit       n1;
        bit       n2;
        calc_op_t op;
        e0 = errors;
        repeat (20) begin
            random_operand(v1, n1);
            random_operand(v2, n2);
            take_bits(2, k);
            op = (k % 3 == 0) ? OP_ADD : ((k % 3 == 1) ? OP_SUB : OP_MUL);
            run_calc(v1, n1, op, v2, n2);
        end
        report_test("random calculations", e0);
    endtask

    initial begin
        int e0;
        nRST           = 1'b0;
        keypad_input   = 4'd0;
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        lfsr_state     = 32'h4ec5_05eb;
        repeat (5) @(posedge clk);
        nRST <= 1'b1;

        reset_values();
        e0 = errors;
        run_calc(12, 1'b0, OP_ADD, 34, 1'b0);
        report_test("add 12 and 34", e0);
        e0 = errors;
        run_calc(5, 1'b0, OP_SUB, 9, 1'b0);
        run_calc(7, 1'b0, OP_SUB, 7, 1'b0);
        report_test("subtract", e0);
        e0 = errors;
        run_calc(7, 1'b1, OP_MUL, 6, 1'b0);
        run_calc(7, 1'b1, OP_MUL, 6, 1'b1);
        run_calc(40000, 1'b0, OP_ADD, 1, 1'b0);
        report_test("negate, multiply and wrap", e0);
        ignored_keys();
        random_calculations();

        $display("Tests passed %0d, tests failed %0d, failed checks %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+src
src/calc_pkg.sv
src/key_event_sync.sv
src/calc_controller.sv
src/signmag_adder.sv
src/shift_add_multiplier.sv
src/calculator_top.sv
verification/calculator_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module calculator_tb \
    -o calc_sim > build.log 2>&1 \
    && ./obj_dir/calc_sim > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "TEST FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
